// File: rtl/ps2_mouse_pkg.sv
package ps2_mouse_pkg;

  // Position counter width and raw delta width
  localparam int POS_BITS   = 11;
  localparam int DELTA_BITS = 9;  // Sign from byte 0 plus 8-bit magnitude

  // PS/2 clock glitch filter
  localparam int SYNC_SAMPLES = 3;
  localparam int FILT_BITS    = $clog2(SYNC_SAMPLES);

  // Drop a half-received frame after this many quiet cycles
  localparam int RX_TIMEOUT_CYCLES = 5000;
  localparam int TIMEOUT_BITS      = $clog2(RX_TIMEOUT_CYCLES);

  // Byte 0 bit positions of a standard packet
  localparam int B0_SYNC_BIT  = 3;
  localparam int B0_XSIGN_BIT = 4;
  localparam int B0_YSIGN_BIT = 5;
  localparam int B0_XOVF_BIT  = 6;
  localparam int B0_YOVF_BIT  = 7;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    DEC_BYTE0,
    DEC_BYTE1,
    DEC_BYTE2
  } dec_state_t;

  // Decoded mouse packet, 23 bits
  typedef struct packed {
    logic [2:0]            buttons;  // Middle, right, left
    logic                  x_ovf;
    logic                  y_ovf;
    logic [DELTA_BITS-1:0] dx;       // Two's complement
    logic [DELTA_BITS-1:0] dy;
  } mouse_packet_t;

endpackage

// File: rtl/ps2_frame_rx.sv
`timescale 1ns/100ps

module ps2_frame_rx import ps2_mouse_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_dat,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       rx_err
);

  logic [1:0]              clk_sync;   // Two-stage synchronizers
  logic [1:0]              dat_sync;
  logic                    clk_filt;   // Filtered PS/2 clock level
  logic [FILT_BITS-1:0]    filt_cnt;
  logic                    clk_fall;
  logic                    dat_bit;

  rx_state_t               state;
  logic [2:0]              bit_cnt;
  logic [7:0]              shift_reg;
  logic                    parity_ok;
  logic [TIMEOUT_BITS-1:0] quiet_cnt;
  logic                    timeout;

  // Lines idle high, so reset to 1 to avoid a false edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
    end
    else
    begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_dat};
    end
  end

  // Level changes only after SYNC_SAMPLES differing samples in a row
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clk_filt <= 1'b1;
      filt_cnt <= '0;
    end
    else if (clk_sync[1] == clk_filt)
      filt_cnt <= '0;
    else if (filt_cnt == FILT_BITS'(SYNC_SAMPLES - 1))
    begin
      clk_filt <= clk_sync[1];
      filt_cnt <= '0;
    end
    else
      filt_cnt <= filt_cnt + 1'b1;
  end

  // Falling edge seen on the sample that flips the filter
  assign clk_fall = clk_filt && !clk_sync[1] &&
                    (filt_cnt == FILT_BITS'(SYNC_SAMPLES - 1));
  assign dat_bit  = dat_sync[1];
  assign timeout  = (quiet_cnt == TIMEOUT_BITS'(RX_TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      quiet_cnt <= '0;
      rx_valid  <= 1'b0;
      rx_err    <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;

      if (state == RX_IDLE || clk_fall)
        quiet_cnt <= '0;
      else
        quiet_cnt <= quiet_cnt + 1'b1;

      if (state != RX_IDLE && timeout && !clk_fall)
        state <= RX_IDLE;  // Truncated frame, start over
      else if (clk_fall)
      begin
        case (state)
          RX_IDLE:
          begin
            if (!dat_bit)  // Start bit
            begin
              bit_cnt <= '0;
              state   <= RX_DATA;
            end
          end
          RX_DATA:
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= RX_PARITY;
          end
          RX_PARITY:
            state <= RX_STOP;
          RX_STOP:
          begin
            if (dat_bit && parity_ok)
              rx_valid <= 1'b1;
            else
              rx_err <= 1'b1;
            state <= RX_IDLE;
          end
          default:
            state <= RX_IDLE;
        endcase
      end
    end
  end

  // Data path, LSB first
  always_ff @(posedge clk)
  begin
    if (clk_fall)
    begin
      if (state == RX_DATA)
        shift_reg <= {dat_bit, shift_reg[7:1]};
      if (state == RX_PARITY)
        parity_ok <= ^{shift_reg, dat_bit};  // Odd parity over 9 bits
      if (state == RX_STOP)
        rx_byte <= shift_reg;
    end
  end

endmodule

// File: rtl/mouse_packet_decoder.sv
`timescale 1ns/100ps

module mouse_packet_decoder import ps2_mouse_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic [7:0]    rx_byte,
  input  logic          rx_valid,
  input  logic          rx_err,
  output mouse_packet_t packet,
  output logic          packet_valid,
  output logic          sync_err
);

  dec_state_t state;
  logic [7:0] byte0;
  logic [7:0] byte1;
  logic       sync_ok;

  assign sync_ok = rx_byte[B0_SYNC_BIT];  // Always set in a real byte 0

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= DEC_BYTE0;
      packet_valid <= 1'b0;
      sync_err     <= 1'b0;
    end
    else
    begin
      packet_valid <= 1'b0;
      sync_err     <= 1'b0;

      if (rx_err)
        state <= DEC_BYTE0;  // Drop the whole packet
      else if (rx_valid)
      begin
        case (state)
          DEC_BYTE0:
          begin
            if (sync_ok)
              state <= DEC_BYTE1;
            else
              sync_err <= 1'b1;
          end
          DEC_BYTE1:
            state <= DEC_BYTE2;
          DEC_BYTE2:
          begin
            packet_valid <= 1'b1;
            state        <= DEC_BYTE0;
          end
          default:
            state <= DEC_BYTE0;
        endcase
      end
    end
  end

  // Byte storage
  always_ff @(posedge clk)
  begin
    if (rx_valid && !rx_err)
    begin
      if (state == DEC_BYTE0 && sync_ok)
        byte0 <= rx_byte;
      if (state == DEC_BYTE1)
        byte1 <= rx_byte;
    end
  end

  // Packet assembled as byte 2 arrives
  always_ff @(posedge clk)
  begin
    if (rx_valid && !rx_err && state == DEC_BYTE2)
    begin
      packet.buttons <= byte0[2:0];
      packet.x_ovf   <= byte0[B0_XOVF_BIT];
      packet.y_ovf   <= byte0[B0_YOVF_BIT];
      packet.dx      <= {byte0[B0_XSIGN_BIT], byte1};
      packet.dy      <= {byte0[B0_YSIGN_BIT], rx_byte};
    end
  end

endmodule

// File: rtl/mouse_report.sv
`timescale 1ns/100ps

module mouse_report import ps2_mouse_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  mouse_packet_t       packet,
  input  logic                packet_valid,
  input  logic                rx_err,
  input  logic                sync_err,
  output logic [POS_BITS-1:0] x_pos,
  output logic [POS_BITS-1:0] y_pos,
  output logic [2:0]          buttons,
  output logic                report_valid,
  output logic [7:0]          led
);

  logic [POS_BITS-1:0] x_step;
  logic [POS_BITS-1:0] y_step;
  logic                sync_lost;  // Sticky until reset
  logic                frame_bad;

  // Sign-extended deltas, zero on overflow
  assign x_step = packet.x_ovf ? '0 :
                  {{(POS_BITS-DELTA_BITS){packet.dx[DELTA_BITS-1]}}, packet.dx};
  assign y_step = packet.y_ovf ? '0 :
                  {{(POS_BITS-DELTA_BITS){packet.dy[DELTA_BITS-1]}}, packet.dy};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x_pos        <= '0;
      y_pos        <= '0;
      buttons      <= '0;
      report_valid <= 1'b0;
      sync_lost    <= 1'b0;
      frame_bad    <= 1'b0;
    end
    else
    begin
      report_valid <= packet_valid;
      if (packet_valid)
      begin
        x_pos   <= x_pos + x_step;  // Wraps modulo 2**POS_BITS
        y_pos   <= y_pos + y_step;
        buttons <= packet.buttons;
      end
      if (sync_err)
        sync_lost <= 1'b1;
      if (rx_err)
        frame_bad <= 1'b1;
    end
  end

  assign led = {frame_bad, sync_lost, y_pos[1:0], x_pos[1:0], buttons[1:0]};

endmodule

// File: rtl/ps2_mouse_top.sv
`timescale 1ns/100ps

module ps2_mouse_top import ps2_mouse_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                ps2_clk,
  input  logic                ps2_dat,
  output logic [POS_BITS-1:0] x_pos,
  output logic [POS_BITS-1:0] y_pos,
  output logic [2:0]          buttons,
  output logic                report_valid,
  output logic [7:0]          led
);

  logic [7:0]    rx_byte;
  logic          rx_valid;
  logic          rx_err;  // Also feeds the frame error LED
  mouse_packet_t packet;
  logic          packet_valid;
  logic          sync_err;

  ps2_frame_rx u_rx (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_dat  (ps2_dat),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_err   (rx_err)
  );

  mouse_packet_decoder u_decoder (
    .clk          (clk),
    .rst          (rst),
    .rx_byte      (rx_byte),
    .rx_valid     (rx_valid),
    .rx_err       (rx_err),
    .packet       (packet),
    .packet_valid (packet_valid),
    .sync_err     (sync_err)
  );

  mouse_report u_report (
    .clk          (clk),
    .rst          (rst),
    .packet       (packet),
    .packet_valid (packet_valid),
    .rx_err       (rx_err),
    .sync_err     (sync_err),
    .x_pos        (x_pos),
    .y_pos        (y_pos),
    .buttons      (buttons),
    .report_valid (report_valid),
    .led          (led)
  );

endmodule

// File: bench/ps2_mouse_props.sv
`timescale 1ns/100ps

module ps2_mouse_props
(
  input logic       clk,
  input logic       rst,
  input logic       rx_valid,
  input logic       rx_err,
  input logic       packet_valid,
  input logic       report_valid,
  input logic [7:0] led
);

  // Report stage is exactly one register behind the decoder
  a_report_follows: assert property (@(posedge clk) disable iff (rst)
    packet_valid |=> report_valid)
    else $error("report_valid missing one cycle after packet_valid");

  a_report_cause: assert property (@(posedge clk) disable iff (rst)
    report_valid |-> $past(packet_valid))
    else $error("report_valid without packet_valid one cycle before");

  a_rx_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(rx_valid && rx_err))
    else $error("rx_valid and rx_err high together");

  a_report_pulse: assert property (@(posedge clk) disable iff (rst)
    report_valid |=> !report_valid)
    else $error("report_valid high for two cycles");

  // Sticky flags clear only through reset
  a_sync_sticky: assert property (@(posedge clk)
    ($past(led[6]) && !$past(rst)) |-> led[6])
    else $error("sync-loss LED cleared without reset");

  a_frame_sticky: assert property (@(posedge clk)
    ($past(led[7]) && !$past(rst)) |-> led[7])
    else $error("frame-error LED cleared without reset");

endmodule

bind ps2_mouse_top ps2_mouse_props u_props (
  .clk          (clk),
  .rst          (rst),
  .rx_valid     (rx_valid),
  .rx_err       (rx_err),
  .packet_valid (packet_valid),
  .report_valid (report_valid),
  .led          (led)
);

// File: bench/ps2_mouse_tb.sv
`timescale 1ns/100ps

module ps2_mouse_tb import ps2_mouse_pkg::*; ();

  localparam int          HALF_PERIOD  = 50;  // PS/2 half bit, in clk cycles
  localparam int          FRAME_GAP    = 100;
  localparam int          FRAME_CYCLES = 22 * HALF_PERIOD + FRAME_GAP;
  localparam int          NUM_FRAMES   = 51;
  localparam int          NUM_PACKETS  = 15;
  localparam int          REPORT_WAIT  = 400;
  localparam int          QUIET_WAIT   = 200;
  localparam int          MAX_CYCLES   = 2 * (NUM_FRAMES * FRAME_CYCLES +
    NUM_PACKETS * REPORT_WAIT + 5 * QUIET_WAIT + RX_TIMEOUT_CYCLES);
  localparam int          POS_MASK     = (1 << POS_BITS) - 1;
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

  logic                clk;
  logic                rst;
  logic                ps2_clk;
  logic                ps2_dat;
  logic [POS_BITS-1:0] x_pos;
  logic [POS_BITS-1:0] y_pos;
  logic [2:0]          buttons;
  logic                report_valid;
  logic [7:0]          led;

  int          errors = 0;
  int          cycle_count = 0;
  int          report_count = 0;
  logic [31:0] lfsr = 32'ha43b3755;
  int          exp_x, exp_y, exp_btn, exp_sync, exp_frame;  // Reference model

  ps2_mouse_top u_ps2_mouse_top (
    .clk          (clk),
    .rst          (rst),
    .ps2_clk      (ps2_clk),
    .ps2_dat      (ps2_dat),
    .x_pos        (x_pos),
    .y_pos        (y_pos),
    .buttons      (buttons),
    .report_valid (report_valid),
    .led          (led)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(negedge clk)
  begin
    if (report_valid)
      report_count++;  // Counted mid-cycle, away from the edge
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
  endfunction

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = next_lfsr(lfsr);
    end
    return val;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;  // Drive just after the edge
  endtask

  task automatic check(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    wait_cycles(2);
    rst       = 1'b0;
    exp_x     = 0;
    exp_y     = 0;
    exp_btn   = 0;
    exp_sync  = 0;
    exp_frame = 0;
  endtask

  // Start, 8 data LSB first, parity, stop; abort_bits > 0 cuts the frame short
  task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                            input logic stop_bit, input int abort_bits);
    logic        par;
    logic [10:0] frame;
    int          nbits;
    par   = ~^data ^ bad_parity;
    frame = {stop_bit, par, data, 1'b0};
    nbits = (abort_bits > 0) ? abort_bits : 11;
    for (int i = 0; i < nbits; i++)
    begin
      ps2_dat = frame[i];
      wait_cycles(HALF_PERIOD);
      ps2_clk = 1'b0;
      wait_cycles(HALF_PERIOD);
      ps2_clk = 1'b1;
    end
    ps2_dat = 1'b1;
    wait_cycles(FRAME_GAP);
  endtask

  task automatic send_packet(input logic [2:0] btn, input int dx, input int dy,
                             input logic xovf, input logic yovf);
    logic [7:0] byte0;
    byte0 = {yovf, xovf, dy < 0, dx < 0, 1'b1, btn};
    send_frame(byte0, 1'b0, 1'b1, 0);
    send_frame(8'(dx), 1'b0, 1'b1, 0);
    send_frame(8'(dy), 1'b0, 1'b1, 0);
  endtask

  task automatic check_outputs(input string name);
    int led_exp;
    led_exp = (exp_frame << 7) | (exp_sync << 6) | ((exp_y & 3) << 4) |
              ((exp_x & 3) << 2) | (exp_btn & 3);
    check({name, " x_pos"}, exp_x, int'(x_pos));
    check({name, " y_pos"}, exp_y, int'(y_pos));
    check({name, " buttons"}, exp_btn, int'(buttons));
    check({name, " led"}, led_exp, int'(led));
  endtask

  task automatic await_report(input string name, input int start);
    int waited;
    waited = 0;
    while (report_count == start && waited < REPORT_WAIT)
    begin
      wait_cycles(1);
      waited++;
    end
    if (report_count == start)
    begin
      $display("%s: report_valid never pulsed after the packet", name);
      errors++;
    end
    else
      check({name, " report count"}, start + 1, report_count);
  endtask

  task automatic good_packet(input string name, input logic [2:0] btn,
                             input int dx, input int dy,
                             input logic xovf, input logic yovf);
    int start;
    start = report_count;
    send_packet(btn, dx, dy, xovf, yovf);
    if (!xovf)
      exp_x = (exp_x + dx) & POS_MASK;  // Positions wrap at 2048
    if (!yovf)
      exp_y = (exp_y + dy) & POS_MASK;
    exp_btn = int'(btn);
    await_report(name, start);
    check_outputs(name);
  endtask

  task automatic expect_no_report(input string name, input int start);
    wait_cycles(QUIET_WAIT);
    check({name, " report count"}, start, report_count);
    check_outputs(name);
  endtask

  task automatic random_packets();
    int raw_x, raw_y, btn;
    for (int i = 0; i < 8; i++)
    begin
      raw_x = take_bits(9);
      raw_y = take_bits(9);
      btn   = take_bits(3);
      good_packet("random", 3'(btn), (raw_x >= 256) ? raw_x - 512 : raw_x,
                  (raw_y >= 256) ? raw_y - 512 : raw_y, 1'b0, 1'b0);
    end
  endtask

  task automatic negative_wrap();
    apply_reset();
    good_packet("wrap", 3'b000, -5, -256, 1'b0, 1'b0);
    check("wrap x_pos literal", 2043, int'(x_pos));
    check("wrap y_pos literal", 1792, int'(y_pos));
  endtask

  task automatic overflow_hold();
    good_packet("overflow x", 3'b101, 77, -30, 1'b1, 1'b0);
    good_packet("overflow y", 3'b010, -12, 99, 1'b0, 1'b1);
  endtask

  // Bad byte 1 drops the packet, so byte 2 is never sent
  task automatic frame_errors();
    int start;
    start = report_count;
    send_frame(8'h0a, 1'b0, 1'b1, 0);
    send_frame(8'h21, 1'b1, 1'b1, 0);  // Parity error
    exp_frame = 1;
    expect_no_report("parity error", start);
    good_packet("after parity", 3'b001, 14, 3, 1'b0, 1'b0);
    start = report_count;
    send_frame(8'h0c, 1'b0, 1'b1, 0);
    send_frame(8'h40, 1'b0, 1'b0, 0);  // Stop bit low
    expect_no_report("stop error", start);
    good_packet("after stop", 3'b110, -40, 25, 1'b0, 1'b0);
  endtask

  task automatic sync_loss();
    int start;
    start = report_count;
    send_frame(8'h07, 1'b0, 1'b1, 0);  // Bit 3 clear
    exp_sync = 1;
    expect_no_report("sync loss", start);
    good_packet("after sync", 3'b011, 60, -60, 1'b0, 1'b0);
  endtask

  task automatic truncated_frame();
    int start;
    start = report_count;
    send_frame(8'h55, 1'b0, 1'b1, 5);
    wait_cycles(RX_TIMEOUT_CYCLES);
    expect_no_report("truncated", start);
    good_packet("after truncated", 3'b100, 9, -17, 1'b0, 1'b0);
  endtask

  initial
  begin
    rst     = 1'b1;
    ps2_clk = 1'b1;  // Idle bus
    ps2_dat = 1'b1;
    apply_reset();
    check_outputs("reset");
    random_packets();
    negative_wrap();
    overflow_hold();
    frame_errors();
    sync_loss();
    truncated_frame();
    $display("Checks done, errors: %0d", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: src.f
rtl/ps2_mouse_pkg.sv
rtl/ps2_frame_rx.sv
rtl/mouse_packet_decoder.sv
rtl/mouse_report.sv
rtl/ps2_mouse_top.sv
bench/ps2_mouse_props.sv
bench/ps2_mouse_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PS/2 mouse testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ps2_mouse_tb \
  -f src.f -o ps2_mouse_sim

./obj_dir/ps2_mouse_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
